//--- msrh_mini.f
+incdir+source
source/msrh_mini_inst_pkg.sv
source/msrh_mini_ctrl_pkg.sv
source/msrh_mini_dispatch.sv
source/msrh_mini_issue_queue.sv
source/msrh_mini_int_alu.sv
source/msrh_mini_int_regfile.sv
source/msrh_mini_tile.sv
sim/tb_msrh_mini_tile.sv

//--- run_msrh_mini.sh
#!/usr/bin/env bash
# Build and run the tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=msrh_mini_sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_msrh_mini_tile \
  -Mdir "$BUILD_DIR" -o Vtb_msrh_mini_tile \
  -f msrh_mini.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_msrh_mini_tile" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG_FILE"; then
  exit 0
else
  echo "Pass message not found in $LOG_FILE"
  exit 1
fi

//--- sim/msrh_mini_patterns.txt
# Columns are group, opcode, rd, rs1, rs2, immediate and expected result, all hex
# Opcodes 0 add 1 sub 2 and 3 or 4 xor 5 li 6 mul
# Group 2 runs with random gaps
2 5 1 0 0 1234 1234
2 5 2 0 0 00ff 00ff
2 0 3 1 2 0000 1333
2 1 4 2 1 0000 eecb
2 2 5 1 2 0000 0034
2 3 6 1 2 0000 12ff
2 4 7 1 2 0000 12cb
2 5 0 0 0 ffff ffff
2 0 1 0 2 0000 00fe
# Group 3 is a back-to-back dependent chain
3 5 1 0 0 0003 0003
3 0 2 1 1 0000 0006
3 0 3 2 1 0000 0009
3 1 1 3 2 0000 0003
3 4 2 1 3 0000 000a
3 3 3 2 1 0000 000b
3 2 4 3 2 0000 000a
3 0 4 4 4 0000 0014
# Group 5 stalls issue behind multiplies
5 5 5 0 0 1234 1234
5 5 6 0 0 0011 0011
5 6 7 5 6 0000 3574
5 0 1 7 6 0000 3585
5 1 2 1 5 0000 2351
5 2 3 2 7 0000 2150
5 3 4 3 6 0000 2151
5 4 0 4 5 0000 3365
5 6 1 0 0 0000 65d9
5 0 2 1 1 0000 cbb2

//--- sim/tb_msrh_mini_tile.sv
`default_nettype none
`timescale 1ns/100ps

`include "msrh_mini_defs.svh"

module tb_msrh_mini_tile;

  localparam int          ACCEPT_TIMEOUT = 100;
  localparam int          DRAIN_TIMEOUT  = 200;
  localparam int          MUL_MAX_AHEAD  = 5;
  localparam int          GAP_GROUP      = 2;
  localparam logic [31:0] SEED           = 32'h62c2_4480;

  logic                         clk;
  logic                         arst_n;
  logic                         inst_valid;
  msrh_mini_inst_pkg::op_t      inst_op;
  msrh_mini_inst_pkg::reg_idx_t inst_rd;
  msrh_mini_inst_pkg::reg_idx_t inst_rs1;
  msrh_mini_inst_pkg::reg_idx_t inst_rs2;
  msrh_mini_inst_pkg::imm_t     inst_imm;
  logic                         inst_ready;
  logic                         done_valid;
  msrh_mini_ctrl_pkg::cmt_id_t  done_cmt_id;
  msrh_mini_inst_pkg::reg_idx_t done_rd;
  msrh_mini_inst_pkg::xdata_t   done_data;

  // Reference register state and pending completions
  msrh_mini_inst_pkg::xdata_t   ref_regs [`MSRH_MINI_REG_NUM];
  msrh_mini_ctrl_pkg::cmt_id_t  next_cmt_id;
  msrh_mini_ctrl_pkg::cmt_id_t  pend_cmt_q [$];
  msrh_mini_inst_pkg::reg_idx_t pend_rd_q [$];
  msrh_mini_inst_pkg::xdata_t   pend_data_q [$];

  int                           errors;
  int                           order_errors;
  int                           orphan_dones;
  int                           accepted;
  int                           completed;
  logic                         abort;

  // Oldest multiply still in flight
  logic                         mul_watch;
  msrh_mini_ctrl_pkg::cmt_id_t  mul_cmt_id;
  int                           after_mul;
  logic                         ready_fell;

  msrh_mini_tile dut (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .i_inst_valid  (inst_valid),
    .i_inst_op     (inst_op),
    .i_inst_rd     (inst_rd),
    .i_inst_rs1    (inst_rs1),
    .i_inst_rs2    (inst_rs2),
    .i_inst_imm    (inst_imm),
    .o_inst_ready  (inst_ready),
    .o_done_valid  (done_valid),
    .o_done_cmt_id (done_cmt_id),
    .o_done_rd     (done_rd),
    .o_done_data   (done_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  function automatic msrh_mini_inst_pkg::xdata_t model_result(
    input msrh_mini_inst_pkg::op_t    op,
    input msrh_mini_inst_pkg::xdata_t a,
    input msrh_mini_inst_pkg::xdata_t b,
    input msrh_mini_inst_pkg::imm_t   imm
  );
    msrh_mini_inst_pkg::xdata_t res;
    case (op)
      msrh_mini_inst_pkg::OP_ADD: res = a + b;
      msrh_mini_inst_pkg::OP_SUB: res = a - b;
      msrh_mini_inst_pkg::OP_AND: res = a & b;
      msrh_mini_inst_pkg::OP_OR:  res = a | b;
      msrh_mini_inst_pkg::OP_XOR: res = a ^ b;
      msrh_mini_inst_pkg::OP_LI:  res = imm;
      msrh_mini_inst_pkg::OP_MUL: res = a * b;
      default:                    res = '0;
    endcase
    return res;
  endfunction

  function automatic string group_name(input int grp);
    string name;
    case (grp)
      2:       name = "alu ops";
      3:       name = "dependent forwarding";
      5:       name = "multiply back-pressure";
      default: name = "pattern group";
    endcase
    return name;
  endfunction

  task automatic report_test(input int num, input string name, input int fails);
    $display("Test %0d %s: %s (%0d failures)", num, name,
             (fails == 0) ? "passed" : "failed", fails);
  endtask

  // ------------------------------------------------------------------------
  // Completion monitor
  // ------------------------------------------------------------------------
  task automatic check_done();
    msrh_mini_ctrl_pkg::cmt_id_t  exp_cmt;
    msrh_mini_inst_pkg::reg_idx_t exp_rd;
    msrh_mini_inst_pkg::xdata_t   exp_data;
    if (pend_cmt_q.size() == 0) begin
      errors++;
      orphan_dones++;
      $display("Completion with commit id 0x%h arrived with nothing pending", done_cmt_id);
    end else begin
      exp_cmt  = pend_cmt_q.pop_front();
      exp_rd   = pend_rd_q.pop_front();
      exp_data = pend_data_q.pop_front();
      completed++;
      if (done_cmt_id !== exp_cmt) begin
        errors++;
        order_errors++;
        $display("Error: o_done_cmt_id = 0x%h, expected 0x%h", done_cmt_id, exp_cmt);
      end
      if (done_rd !== exp_rd) begin
        errors++;
        $display("Error: o_done_rd = 0x%h, expected 0x%h", done_rd, exp_rd);
      end
      if (done_data !== exp_data) begin
        errors++;
        $display("Error: o_done_data = 0x%h, expected 0x%h", done_data, exp_data);
      end
      if (mul_watch && (exp_cmt == mul_cmt_id)) begin
        mul_watch = 1'b0;
        if (after_mul > MUL_MAX_AHEAD) begin
          errors++;
          $display("%0d instructions got in behind a multiply before it completed, limit %0d",
                   after_mul, MUL_MAX_AHEAD);
        end
      end
    end
  endtask

  // Sampled on the falling edge where DUT outputs are settled
  always @(negedge clk) begin
    if (arst_n) begin
      if (mul_watch && !inst_ready) begin
        ready_fell = 1'b1;
      end
      if (done_valid) begin
        check_done();
      end
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  task automatic send_inst(
    input msrh_mini_inst_pkg::op_t      op,
    input msrh_mini_inst_pkg::reg_idx_t rd,
    input msrh_mini_inst_pkg::reg_idx_t rs1,
    input msrh_mini_inst_pkg::reg_idx_t rs2,
    input msrh_mini_inst_pkg::imm_t     imm,
    input msrh_mini_inst_pkg::xdata_t   expect_val
  );
    msrh_mini_inst_pkg::xdata_t model;
    int                         waited;
    logic                       taken;
    model  = model_result(op, ref_regs[rs1], ref_regs[rs2], imm);
    waited = 0;
    taken  = 1'b0;
    if (model !== expect_val) begin
      errors++;
      $display("Error: pattern expect = 0x%h, reference model = 0x%h", expect_val, model);
    end
    inst_valid = 1'b1;
    inst_op    = op;
    inst_rd    = rd;
    inst_rs1   = rs1;
    inst_rs2   = rs2;
    inst_imm   = imm;
    // Held until the DUT takes it on a rising edge
    while (!taken && (waited < ACCEPT_TIMEOUT)) begin
      @(negedge clk);
      taken = inst_ready;
      @(posedge clk);
      #1;
      waited++;
    end
    inst_valid = 1'b0;
    if (!taken) begin
      errors++;
      abort = 1'b1;
      $display("Timeout: instruction not accepted within %0d cycles", ACCEPT_TIMEOUT);
    end else begin
      accepted++;
      if (mul_watch) begin
        after_mul++;
      end
      if ((op == msrh_mini_inst_pkg::OP_MUL) && !mul_watch) begin
        mul_watch  = 1'b1;
        mul_cmt_id = next_cmt_id;
        after_mul  = 0;
      end
      pend_cmt_q.push_back(next_cmt_id);
      pend_rd_q.push_back(rd);
      pend_data_q.push_back(expect_val);
      ref_regs[rd] = model;
      next_cmt_id  = next_cmt_id + 1'b1;
    end
  endtask

  task automatic drain_pending();
    int waited;
    waited = 0;
    while ((pend_cmt_q.size() != 0) && (waited < DRAIN_TIMEOUT)) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (pend_cmt_q.size() != 0) begin
      errors++;
      abort = 1'b1;
      $display("Timeout: %0d instructions never completed", pend_cmt_q.size());
    end
  endtask

  task automatic finish_group(input int grp, input int errs_before, input logic has_mul);
    drain_pending();
    if (has_mul && !ready_fell) begin
      errors++;
      $display("o_inst_ready never fell while a multiply was pending");
    end
    report_test(grp, group_name(grp), errors - errs_before);
  endtask

  initial begin
    int          fd;
    int          n;
    int          cur_grp;
    int          grp_errors;
    int          gap;
    logic        grp_has_mul;
    string       line;
    logic [31:0] f_grp;
    logic [31:0] f_op;
    logic [31:0] f_rd;
    logic [31:0] f_rs1;
    logic [31:0] f_rs2;
    logic [31:0] f_imm;
    logic [31:0] f_exp;

    void'($urandom(SEED));
    errors       = 0;
    order_errors = 0;
    orphan_dones = 0;
    accepted     = 0;
    completed    = 0;
    abort        = 1'b0;
    mul_watch    = 1'b0;
    mul_cmt_id   = '0;
    after_mul    = 0;
    ready_fell   = 1'b0;
    next_cmt_id  = '0;
    grp_has_mul  = 1'b0;
    arst_n       = 1'b0;
    inst_valid   = 1'b0;
    inst_op      = msrh_mini_inst_pkg::OP_ADD;
    inst_rd      = '0;
    inst_rs1     = '0;
    inst_rs2     = '0;
    inst_imm     = '0;
    for (int i = 0; i < `MSRH_MINI_REG_NUM; i++) begin
      ref_regs[i] = '0;
    end

    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Idle state right after reset
    grp_errors = errors;
    @(negedge clk);
    if (inst_ready !== 1'b1) begin
      errors++;
      $display("Error: o_inst_ready = 0x%h, expected 0x1", inst_ready);
    end
    if (done_valid !== 1'b0) begin
      errors++;
      $display("Error: o_done_valid = 0x%h, expected 0x0", done_valid);
    end
    report_test(1, "reset state", errors - grp_errors);
    @(posedge clk);
    #1;

    cur_grp = 0;
    fd = $fopen("sim/msrh_mini_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the pattern file sim/msrh_mini_patterns.txt");
    end else begin
      while (!abort && ($fgets(line, fd) != 0)) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h",
                    f_grp, f_op, f_rd, f_rs1, f_rs2, f_imm, f_exp);
        if (n == 7) begin
          if (f_grp != cur_grp) begin
            if (cur_grp != 0) begin
              finish_group(cur_grp, grp_errors, grp_has_mul);
            end
            cur_grp     = f_grp;
            grp_errors  = errors;
            grp_has_mul = 1'b0;
            ready_fell  = 1'b0;
          end else if (cur_grp == GAP_GROUP) begin
            gap = $urandom % 4;
            repeat (gap) begin
              @(posedge clk);
              #1;
            end
          end
          if (f_op[2:0] == msrh_mini_inst_pkg::OP_MUL) begin
            grp_has_mul = 1'b1;
          end
          send_inst(msrh_mini_inst_pkg::op_t'(f_op[2:0]), f_rd[2:0], f_rs1[2:0],
                    f_rs2[2:0], f_imm[15:0], f_exp[15:0]);
        end
      end
      if (cur_grp != 0) begin
        finish_group(cur_grp, grp_errors, grp_has_mul);
      end
      $fclose(fd);
    end

    report_test(4, "completion order and commit ids", order_errors);
    if (completed != accepted) begin
      errors++;
      $display("%0d instructions accepted but %0d completions seen", accepted, completed);
    end
    report_test(6, "one completion per instruction",
                orphan_dones + ((completed != accepted) ? 1 : 0));

    $display("Summary: %0d accepted, %0d completed, %0d errors", accepted, completed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/msrh_mini_ctrl_pkg.sv
`default_nettype none

`include "msrh_mini_defs.svh"

package msrh_mini_ctrl_pkg;

  // Tag carried from dispatch to the completion report
  typedef logic [`MSRH_MINI_CMT_ID_W-1:0] cmt_id_t;

  // Holds 0 up to the full queue depth
  typedef logic [$clog2(`MSRH_MINI_IQ_DEPTH+1)-1:0] credit_t;

  // Integer pipe EX2 state
  typedef enum logic {
    ALU_IDLE = 1'b0,
    ALU_MUL  = 1'b1
  } alu_state_t;

endpackage

`default_nettype wire

//--- source/msrh_mini_defs.svh
`ifndef MSRH_MINI_DEFS_SVH
`define MSRH_MINI_DEFS_SVH

// Integer data path width
`define MSRH_MINI_XLEN 16

// Architectural integer registers
`define MSRH_MINI_REG_NUM 8

// Issue queue entries, also the number of dispatch credits
`define MSRH_MINI_IQ_DEPTH 4

// Commit id width, the id wraps
`define MSRH_MINI_CMT_ID_W 6

// Shift-add multiply, one multiplier bit per cycle
`define MSRH_MINI_MUL_CYCLES 16

`endif

//--- source/msrh_mini_dispatch.sv
`default_nettype none
`timescale 1ns/100ps

`include "msrh_mini_defs.svh"

module msrh_mini_dispatch (
  input  wire                          i_clk,
  input  wire                          i_arst_n,

  input  wire                          i_inst_valid,
  input  msrh_mini_inst_pkg::op_t      i_inst_op,
  input  msrh_mini_inst_pkg::reg_idx_t i_inst_rd,
  input  msrh_mini_inst_pkg::reg_idx_t i_inst_rs1,
  input  msrh_mini_inst_pkg::reg_idx_t i_inst_rs2,
  input  msrh_mini_inst_pkg::imm_t     i_inst_imm,
  output logic                         o_inst_ready,

  input  wire                          i_iq_credit,
  output logic                         o_iq_push,
  output msrh_mini_inst_pkg::op_t      o_iq_op,
  output msrh_mini_inst_pkg::reg_idx_t o_iq_rd,
  output msrh_mini_inst_pkg::reg_idx_t o_iq_rs1,
  output msrh_mini_inst_pkg::reg_idx_t o_iq_rs2,
  output msrh_mini_inst_pkg::imm_t     o_iq_imm,
  output msrh_mini_ctrl_pkg::cmt_id_t  o_iq_cmt_id
);

  msrh_mini_ctrl_pkg::credit_t credit_q;
  msrh_mini_ctrl_pkg::cmt_id_t cmt_id_q;
  logic                        accept;

  // Accept only while the queue has a free slot reserved for us
  assign o_inst_ready = (credit_q != '0);
  assign accept       = i_inst_valid && o_inst_ready;

  // Spend on accept, regain on each freed queue entry
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      credit_q  <= msrh_mini_ctrl_pkg::credit_t'(`MSRH_MINI_IQ_DEPTH);
      cmt_id_q  <= '0;
      o_iq_push <= 1'b0;
    end else begin
      credit_q  <= credit_q - msrh_mini_ctrl_pkg::credit_t'(accept)
                            + msrh_mini_ctrl_pkg::credit_t'(i_iq_credit);
      o_iq_push <= accept;
      if (accept) begin
        cmt_id_q <= cmt_id_q + 1'b1;
      end
    end
  end

  // Push payload, stamped with the commit id at acceptance
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_iq_op     <= i_inst_op;
      o_iq_rd     <= i_inst_rd;
      o_iq_rs1    <= i_inst_rs1;
      o_iq_rs2    <= i_inst_rs2;
      o_iq_imm    <= i_inst_imm;
      o_iq_cmt_id <= cmt_id_q;
    end
  end

endmodule

`default_nettype wire

//--- source/msrh_mini_inst_pkg.sv
`default_nettype none

`include "msrh_mini_defs.svh"

package msrh_mini_inst_pkg;

  // Integer pipe operations
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_LI  = 3'd5,
    OP_MUL = 3'd6
  } op_t;

  // Architectural register index
  typedef logic [$clog2(`MSRH_MINI_REG_NUM)-1:0] reg_idx_t;

  typedef logic [`MSRH_MINI_XLEN-1:0] xdata_t;

  // Immediate, used by load-immediate only
  typedef logic [`MSRH_MINI_XLEN-1:0] imm_t;

endpackage

`default_nettype wire

//--- source/msrh_mini_int_alu.sv
`default_nettype none
`timescale 1ns/100ps

`include "msrh_mini_defs.svh"

module msrh_mini_int_alu (
  input  wire                          i_clk,
  input  wire                          i_arst_n,

  input  wire                          i_issue_valid,
  input  msrh_mini_inst_pkg::op_t      i_issue_op,
  input  msrh_mini_inst_pkg::reg_idx_t i_issue_rd,
  input  msrh_mini_inst_pkg::reg_idx_t i_issue_rs1,
  input  msrh_mini_inst_pkg::reg_idx_t i_issue_rs2,
  input  msrh_mini_inst_pkg::imm_t     i_issue_imm,
  input  msrh_mini_ctrl_pkg::cmt_id_t  i_issue_cmt_id,
  output logic                         o_issue_ready,

  output msrh_mini_inst_pkg::reg_idx_t o_rs1_idx,
  output msrh_mini_inst_pkg::reg_idx_t o_rs2_idx,
  input  msrh_mini_inst_pkg::xdata_t   i_rs1_data,
  input  msrh_mini_inst_pkg::xdata_t   i_rs2_data,

  output logic                         o_wr_en,
  output msrh_mini_inst_pkg::reg_idx_t o_wr_idx,
  output msrh_mini_inst_pkg::xdata_t   o_wr_data,

  output logic                         o_done_valid,
  output msrh_mini_ctrl_pkg::cmt_id_t  o_done_cmt_id,
  output msrh_mini_inst_pkg::reg_idx_t o_done_rd,
  output msrh_mini_inst_pkg::xdata_t   o_done_data
);

  localparam int MUL_CNT_W = $clog2(`MSRH_MINI_MUL_CYCLES);

  msrh_mini_ctrl_pkg::alu_state_t state_q;
  logic [MUL_CNT_W-1:0]           mul_cnt_q;

  // EX1 holds the issued instruction while its operands are read
  logic                           ex1_valid_q;
  msrh_mini_inst_pkg::op_t        ex1_op_q;
  msrh_mini_inst_pkg::reg_idx_t   ex1_rd_q;
  msrh_mini_inst_pkg::reg_idx_t   ex1_rs1_q;
  msrh_mini_inst_pkg::reg_idx_t   ex1_rs2_q;
  msrh_mini_inst_pkg::imm_t       ex1_imm_q;
  msrh_mini_ctrl_pkg::cmt_id_t    ex1_cmt_id_q;
  msrh_mini_inst_pkg::xdata_t     ex1_op1;
  msrh_mini_inst_pkg::xdata_t     ex1_op2;

  // EX2 computes; op1 and op2 double as multiply shift registers
  logic                           ex2_valid_q;
  msrh_mini_inst_pkg::op_t        ex2_op_q;
  msrh_mini_inst_pkg::reg_idx_t   ex2_rd_q;
  msrh_mini_inst_pkg::imm_t       ex2_imm_q;
  msrh_mini_ctrl_pkg::cmt_id_t    ex2_cmt_id_q;
  msrh_mini_inst_pkg::xdata_t     ex2_op1_q;
  msrh_mini_inst_pkg::xdata_t     ex2_op2_q;
  msrh_mini_inst_pkg::xdata_t     mul_prod_q;
  msrh_mini_inst_pkg::xdata_t     ex2_result;
  logic                           ex2_wr;
  logic                           pipe_idle;

  assign pipe_idle     = (state_q == msrh_mini_ctrl_pkg::ALU_IDLE);
  assign o_issue_ready = pipe_idle;

  // ------------------------------------------------------------------------
  // EX1 operand read with forwarding from EX2
  // ------------------------------------------------------------------------
  assign o_rs1_idx = ex1_rs1_q;
  assign o_rs2_idx = ex1_rs2_q;
  assign ex1_op1   = (ex2_wr && (ex2_rd_q == ex1_rs1_q)) ? ex2_result : i_rs1_data;
  assign ex1_op2   = (ex2_wr && (ex2_rd_q == ex1_rs2_q)) ? ex2_result : i_rs2_data;

  // ------------------------------------------------------------------------
  // EX2 result and write back
  // ------------------------------------------------------------------------
  always_comb begin
    case (ex2_op_q)
      msrh_mini_inst_pkg::OP_ADD: ex2_result = ex2_op1_q + ex2_op2_q;
      msrh_mini_inst_pkg::OP_SUB: ex2_result = ex2_op1_q - ex2_op2_q;
      msrh_mini_inst_pkg::OP_AND: ex2_result = ex2_op1_q & ex2_op2_q;
      msrh_mini_inst_pkg::OP_OR:  ex2_result = ex2_op1_q | ex2_op2_q;
      msrh_mini_inst_pkg::OP_XOR: ex2_result = ex2_op1_q ^ ex2_op2_q;
      msrh_mini_inst_pkg::OP_LI:  ex2_result = ex2_imm_q;
      msrh_mini_inst_pkg::OP_MUL: ex2_result = mul_prod_q;
      default:                    ex2_result = '0;
    endcase
  end

  // A multiply in EX2 reports only once the FSM is back in idle
  assign ex2_wr        = ex2_valid_q && pipe_idle;
  assign o_wr_en       = ex2_wr;
  assign o_wr_idx      = ex2_rd_q;
  assign o_wr_data     = ex2_result;
  assign o_done_valid  = ex2_wr;
  assign o_done_cmt_id = ex2_cmt_id_q;
  assign o_done_rd     = ex2_rd_q;
  assign o_done_data   = ex2_result;

  // ------------------------------------------------------------------------
  // Pipe control and multiply FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q     <= msrh_mini_ctrl_pkg::ALU_IDLE;
      mul_cnt_q   <= '0;
      ex1_valid_q <= 1'b0;
      ex2_valid_q <= 1'b0;
    end else begin
      case (state_q)
        msrh_mini_ctrl_pkg::ALU_IDLE: begin
          ex1_valid_q <= i_issue_valid;
          ex2_valid_q <= ex1_valid_q;
          mul_cnt_q   <= '0;
          if (ex1_valid_q && (ex1_op_q == msrh_mini_inst_pkg::OP_MUL)) begin
            state_q <= msrh_mini_ctrl_pkg::ALU_MUL;
          end
        end
        msrh_mini_ctrl_pkg::ALU_MUL: begin
          mul_cnt_q <= mul_cnt_q + 1'b1;
          if (mul_cnt_q == MUL_CNT_W'(`MSRH_MINI_MUL_CYCLES - 1)) begin
            state_q <= msrh_mini_ctrl_pkg::ALU_IDLE;
          end
        end
        default: state_q <= msrh_mini_ctrl_pkg::ALU_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (pipe_idle) begin
      ex1_op_q     <= i_issue_op;
      ex1_rd_q     <= i_issue_rd;
      ex1_rs1_q    <= i_issue_rs1;
      ex1_rs2_q    <= i_issue_rs2;
      ex1_imm_q    <= i_issue_imm;
      ex1_cmt_id_q <= i_issue_cmt_id;
      ex2_op_q     <= ex1_op_q;
      ex2_rd_q     <= ex1_rd_q;
      ex2_imm_q    <= ex1_imm_q;
      ex2_cmt_id_q <= ex1_cmt_id_q;
      ex2_op1_q    <= ex1_op1;
      ex2_op2_q    <= ex1_op2;
      mul_prod_q   <= '0;
    end else begin
      // One multiplier bit per cycle, low half of the product kept
      mul_prod_q <= mul_prod_q + (ex2_op2_q[0] ? ex2_op1_q : '0);
      ex2_op1_q  <= ex2_op1_q << 1;
      ex2_op2_q  <= ex2_op2_q >> 1;
    end
  end

endmodule

`default_nettype wire

//--- source/msrh_mini_int_regfile.sv
`default_nettype none
`timescale 1ns/100ps

`include "msrh_mini_defs.svh"

module msrh_mini_int_regfile (
  input  wire                          i_clk,
  input  wire                          i_arst_n,

  input  msrh_mini_inst_pkg::reg_idx_t i_rd0_idx,
  output msrh_mini_inst_pkg::xdata_t   o_rd0_data,
  input  msrh_mini_inst_pkg::reg_idx_t i_rd1_idx,
  output msrh_mini_inst_pkg::xdata_t   o_rd1_data,

  input  wire                          i_wr_en,
  input  msrh_mini_inst_pkg::reg_idx_t i_wr_idx,
  input  msrh_mini_inst_pkg::xdata_t   i_wr_data
);

  msrh_mini_inst_pkg::xdata_t regs_q [`MSRH_MINI_REG_NUM];

  // Reads see the value before any write on this edge
  assign o_rd0_data = regs_q[i_rd0_idx];
  assign o_rd1_data = regs_q[i_rd1_idx];

  // All registers are writable, register 0 included
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `MSRH_MINI_REG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (i_wr_en) begin
      regs_q[i_wr_idx] <= i_wr_data;
    end
  end

endmodule

`default_nettype wire

//--- source/msrh_mini_issue_queue.sv
`default_nettype none
`timescale 1ns/100ps

`include "msrh_mini_defs.svh"

module msrh_mini_issue_queue (
  input  wire                          i_clk,
  input  wire                          i_arst_n,

  input  wire                          i_push,
  input  msrh_mini_inst_pkg::op_t      i_op,
  input  msrh_mini_inst_pkg::reg_idx_t i_rd,
  input  msrh_mini_inst_pkg::reg_idx_t i_rs1,
  input  msrh_mini_inst_pkg::reg_idx_t i_rs2,
  input  msrh_mini_inst_pkg::imm_t     i_imm,
  input  msrh_mini_ctrl_pkg::cmt_id_t  i_cmt_id,
  output logic                         o_credit,

  output logic                         o_issue_valid,
  output msrh_mini_inst_pkg::op_t      o_issue_op,
  output msrh_mini_inst_pkg::reg_idx_t o_issue_rd,
  output msrh_mini_inst_pkg::reg_idx_t o_issue_rs1,
  output msrh_mini_inst_pkg::reg_idx_t o_issue_rs2,
  output msrh_mini_inst_pkg::imm_t     o_issue_imm,
  output msrh_mini_ctrl_pkg::cmt_id_t  o_issue_cmt_id,
  input  wire                          i_issue_ready
);

  localparam int PTR_W = $clog2(`MSRH_MINI_IQ_DEPTH);

  // ------------------------------------------------------------------------
  // Entry storage
  // ------------------------------------------------------------------------
  msrh_mini_inst_pkg::op_t      op_q     [`MSRH_MINI_IQ_DEPTH];
  msrh_mini_inst_pkg::reg_idx_t rd_q     [`MSRH_MINI_IQ_DEPTH];
  msrh_mini_inst_pkg::reg_idx_t rs1_q    [`MSRH_MINI_IQ_DEPTH];
  msrh_mini_inst_pkg::reg_idx_t rs2_q    [`MSRH_MINI_IQ_DEPTH];
  msrh_mini_inst_pkg::imm_t     imm_q    [`MSRH_MINI_IQ_DEPTH];
  msrh_mini_ctrl_pkg::cmt_id_t  cmt_id_q [`MSRH_MINI_IQ_DEPTH];

  // Extra wrap bit tells full from empty
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;
  logic           issue_fire;

  assign o_issue_valid = (wr_ptr_q != rd_ptr_q);
  assign issue_fire    = o_issue_valid && i_issue_ready;
  assign o_credit      = issue_fire;

  // Head entry, in push order
  assign o_issue_op     = op_q    [rd_ptr_q[PTR_W-1:0]];
  assign o_issue_rd     = rd_q    [rd_ptr_q[PTR_W-1:0]];
  assign o_issue_rs1    = rs1_q   [rd_ptr_q[PTR_W-1:0]];
  assign o_issue_rs2    = rs2_q   [rd_ptr_q[PTR_W-1:0]];
  assign o_issue_imm    = imm_q   [rd_ptr_q[PTR_W-1:0]];
  assign o_issue_cmt_id = cmt_id_q[rd_ptr_q[PTR_W-1:0]];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (i_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (issue_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Dispatch credits guarantee a free slot on every push
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      op_q    [wr_ptr_q[PTR_W-1:0]] <= i_op;
      rd_q    [wr_ptr_q[PTR_W-1:0]] <= i_rd;
      rs1_q   [wr_ptr_q[PTR_W-1:0]] <= i_rs1;
      rs2_q   [wr_ptr_q[PTR_W-1:0]] <= i_rs2;
      imm_q   [wr_ptr_q[PTR_W-1:0]] <= i_imm;
      cmt_id_q[wr_ptr_q[PTR_W-1:0]] <= i_cmt_id;
    end
  end

endmodule

`default_nettype wire

//--- source/msrh_mini_tile.sv
`default_nettype none
`timescale 1ns/100ps

module msrh_mini_tile (
  input  wire                          i_clk,
  input  wire                          i_arst_n,

  input  wire                          i_inst_valid,
  input  msrh_mini_inst_pkg::op_t      i_inst_op,
  input  msrh_mini_inst_pkg::reg_idx_t i_inst_rd,
  input  msrh_mini_inst_pkg::reg_idx_t i_inst_rs1,
  input  msrh_mini_inst_pkg::reg_idx_t i_inst_rs2,
  input  msrh_mini_inst_pkg::imm_t     i_inst_imm,
  output logic                         o_inst_ready,

  output logic                         o_done_valid,
  output msrh_mini_ctrl_pkg::cmt_id_t  o_done_cmt_id,
  output msrh_mini_inst_pkg::reg_idx_t o_done_rd,
  output msrh_mini_inst_pkg::xdata_t   o_done_data
);

  // ------------------------------------------------------------------------
  // Dispatch to issue queue
  // ------------------------------------------------------------------------
  logic                         w_iq_push;
  logic                         w_iq_credit;
  msrh_mini_inst_pkg::op_t      w_iq_op;
  msrh_mini_inst_pkg::reg_idx_t w_iq_rd;
  msrh_mini_inst_pkg::reg_idx_t w_iq_rs1;
  msrh_mini_inst_pkg::reg_idx_t w_iq_rs2;
  msrh_mini_inst_pkg::imm_t     w_iq_imm;
  msrh_mini_ctrl_pkg::cmt_id_t  w_iq_cmt_id;

  // ------------------------------------------------------------------------
  // Issue queue to integer pipe
  // ------------------------------------------------------------------------
  logic                         w_issue_valid;
  logic                         w_issue_ready;
  msrh_mini_inst_pkg::op_t      w_issue_op;
  msrh_mini_inst_pkg::reg_idx_t w_issue_rd;
  msrh_mini_inst_pkg::reg_idx_t w_issue_rs1;
  msrh_mini_inst_pkg::reg_idx_t w_issue_rs2;
  msrh_mini_inst_pkg::imm_t     w_issue_imm;
  msrh_mini_ctrl_pkg::cmt_id_t  w_issue_cmt_id;

  // Register file ports
  msrh_mini_inst_pkg::reg_idx_t w_rs1_idx;
  msrh_mini_inst_pkg::reg_idx_t w_rs2_idx;
  msrh_mini_inst_pkg::xdata_t   w_rs1_data;
  msrh_mini_inst_pkg::xdata_t   w_rs2_data;
  logic                         w_wr_en;
  msrh_mini_inst_pkg::reg_idx_t w_wr_idx;
  msrh_mini_inst_pkg::xdata_t   w_wr_data;

  msrh_mini_dispatch u_dispatch (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst_op    (i_inst_op),
    .i_inst_rd    (i_inst_rd),
    .i_inst_rs1   (i_inst_rs1),
    .i_inst_rs2   (i_inst_rs2),
    .i_inst_imm   (i_inst_imm),
    .o_inst_ready (o_inst_ready),
    .i_iq_credit  (w_iq_credit),
    .o_iq_push    (w_iq_push),
    .o_iq_op      (w_iq_op),
    .o_iq_rd      (w_iq_rd),
    .o_iq_rs1     (w_iq_rs1),
    .o_iq_rs2     (w_iq_rs2),
    .o_iq_imm     (w_iq_imm),
    .o_iq_cmt_id  (w_iq_cmt_id)
  );

  msrh_mini_issue_queue u_issue_queue (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_push         (w_iq_push),
    .i_op           (w_iq_op),
    .i_rd           (w_iq_rd),
    .i_rs1          (w_iq_rs1),
    .i_rs2          (w_iq_rs2),
    .i_imm          (w_iq_imm),
    .i_cmt_id       (w_iq_cmt_id),
    .o_credit       (w_iq_credit),
    .o_issue_valid  (w_issue_valid),
    .o_issue_op     (w_issue_op),
    .o_issue_rd     (w_issue_rd),
    .o_issue_rs1    (w_issue_rs1),
    .o_issue_rs2    (w_issue_rs2),
    .o_issue_imm    (w_issue_imm),
    .o_issue_cmt_id (w_issue_cmt_id),
    .i_issue_ready  (w_issue_ready)
  );

  msrh_mini_int_alu u_int_alu (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_issue_valid  (w_issue_valid),
    .i_issue_op     (w_issue_op),
    .i_issue_rd     (w_issue_rd),
    .i_issue_rs1    (w_issue_rs1),
    .i_issue_rs2    (w_issue_rs2),
    .i_issue_imm    (w_issue_imm),
    .i_issue_cmt_id (w_issue_cmt_id),
    .o_issue_ready  (w_issue_ready),
    .o_rs1_idx      (w_rs1_idx),
    .o_rs2_idx      (w_rs2_idx),
    .i_rs1_data     (w_rs1_data),
    .i_rs2_data     (w_rs2_data),
    .o_wr_en        (w_wr_en),
    .o_wr_idx       (w_wr_idx),
    .o_wr_data      (w_wr_data),
    .o_done_valid   (o_done_valid),
    .o_done_cmt_id  (o_done_cmt_id),
    .o_done_rd      (o_done_rd),
    .o_done_data    (o_done_data)
  );

  msrh_mini_int_regfile u_int_regfile (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_rd0_idx  (w_rs1_idx),
    .o_rd0_data (w_rs1_data),
    .i_rd1_idx  (w_rs2_idx),
    .o_rd1_data (w_rs2_data),
    .i_wr_en    (w_wr_en),
    .i_wr_idx   (w_wr_idx),
    .i_wr_data  (w_wr_data)
  );

endmodule

`default_nettype wire
